// ==== Bender.yml ====
package:
  name: dmr_lockstep

sources:
  - files:
      - hw/hmr_pkg.sv
      - hw/core_pkg.sv
      - hw/core_bus_if.sv
      - hw/hmr_cfg_if.sv
      - hw/mini_core.sv
      - hw/lockstep_ctrl.sv
      - hw/hmr_cfg_regs.sv
      - hw/dmr_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/dmr_monitor.sv
      - tb/dmr_tb.sv

// ==== flist.f ====
hw/hmr_pkg.sv
hw/core_pkg.sv
hw/core_bus_if.sv
hw/hmr_cfg_if.sv
hw/mini_core.sv
hw/lockstep_ctrl.sv
hw/hmr_cfg_regs.sv
hw/dmr_top.sv
tb/tb_clk_gen.sv
tb/dmr_monitor.sv
tb/dmr_tb.sv

// ==== hw/core_bus_if.sv ====
/*
 * Lockstep controller to core link: instruction dispatch,
 * recovery writes and the registered result
 */

`timescale 1ns/1ps

interface core_bus_if;

  // Execution request
  logic                                 exec;
  core_pkg::opcode_e                    opcode;
  logic [core_pkg::RF_ADDR_W-1:0]       rd;
  logic [core_pkg::RF_ADDR_W-1:0]       rs1;
  logic [core_pkg::RF_ADDR_W-1:0]       rs2;
  logic [core_pkg::IMM_W-1:0]           imm;
  logic                                 fault;

  // Recovery write port
  logic                                 rec_we;
  logic [core_pkg::RF_ADDR_W-1:0]       rec_addr;
  logic [core_pkg::XLEN-1:0]            rec_data;

  // Valid the cycle after exec
  logic [core_pkg::XLEN-1:0]            result;

  modport ctrl (
    output exec, opcode, rd, rs1, rs2, imm, fault, rec_we, rec_addr, rec_data,
    input  result
  );

  modport core (
    input  exec, opcode, rd, rs1, rs2, imm, fault, rec_we, rec_addr, rec_data,
    output result
  );

endinterface

// ==== hw/core_pkg.sv ====
/*
 * Datapath definitions for the small register-file cores:
 * widths, register count and the opcode set
 */

package core_pkg;

  // Data width
  localparam int unsigned XLEN = 32;

  // Register file geometry
  localparam int unsigned RF_ADDR_W = 5;
  localparam int unsigned NUM_REGS  = 32;

  // Immediate width, zero-extended to XLEN
  localparam int unsigned IMM_W = 16;

  // OP_LI loads the immediate, the rest combine rs1 with rs2
  typedef enum logic [1:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_XOR
  } opcode_e;

endpackage

// ==== hw/dmr_top.sv ====
/*
 * DMR top level. Two lockstepped cores, the lockstep controller
 * and the configuration registers behind plain ports
 */

`timescale 1ns/1ps

module dmr_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Instruction port
  input  logic                            instr_req_i,
  input  core_pkg::opcode_e               instr_op_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rd_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs1_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs2_i,
  input  logic [core_pkg::IMM_W-1:0]      instr_imm_i,
  output logic                            instr_ack_o,
  output logic [core_pkg::XLEN-1:0]       result_o,
  // Register port
  input  logic                            reg_req_i,
  input  logic                            reg_we_i,
  input  logic [hmr_pkg::REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [core_pkg::XLEN-1:0]       reg_wdata_i,
  output logic                            reg_ack_o,
  output logic [core_pkg::XLEN-1:0]       reg_rdata_o
);

  core_bus_if core0_bus ();
  core_bus_if core1_bus ();
  hmr_cfg_if  cfg_bus ();

  mini_core core0 (
    .clk_i ( clk_i     ),
    .rst_i ( rst_i     ),
    .bus   ( core0_bus )
  );

  mini_core core1 (
    .clk_i ( clk_i     ),
    .rst_i ( rst_i     ),
    .bus   ( core1_bus )
  );

  lockstep_ctrl i_lockstep_ctrl (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .instr_req_i ( instr_req_i ),
    .instr_op_i  ( instr_op_i  ),
    .instr_rd_i  ( instr_rd_i  ),
    .instr_rs1_i ( instr_rs1_i ),
    .instr_rs2_i ( instr_rs2_i ),
    .instr_imm_i ( instr_imm_i ),
    .instr_ack_o ( instr_ack_o ),
    .result_o    ( result_o    ),
    .core0       ( core0_bus   ),
    .core1       ( core1_bus   ),
    .cfg         ( cfg_bus     )
  );

  hmr_cfg_regs i_hmr_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .reg_req_i   ( reg_req_i   ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_ack_o   ( reg_ack_o   ),
    .reg_rdata_o ( reg_rdata_o ),
    .cfg         ( cfg_bus     )
  );

endmodule

// ==== hw/hmr_cfg_if.sv ====
/*
 * Configuration block to lockstep controller link
 */

`timescale 1ns/1ps

interface hmr_cfg_if;

  // From the configuration registers
  logic                           dmr_en;
  logic [hmr_pkg::NUM_CORES-1:0]  inject;

  // Status pulses from the controller
  logic [hmr_pkg::NUM_CORES-1:0]  inject_done;
  logic                           mismatch;

  modport regs (
    output dmr_en, inject,
    input  inject_done, mismatch
  );

  modport ctrl (
    input  dmr_en, inject,
    output inject_done, mismatch
  );

endinterface

// ==== hw/hmr_cfg_regs.sv ====
/*
 * Configuration registers of the DMR unit on a four-phase register
 * port: DMR enable, one-shot fault injection and mismatch counter
 */

`timescale 1ns/1ps

module hmr_cfg_regs (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            reg_req_i,
  input  logic                            reg_we_i,
  input  logic [hmr_pkg::REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [core_pkg::XLEN-1:0]       reg_wdata_i,
  output logic                            reg_ack_o,
  output logic [core_pkg::XLEN-1:0]       reg_rdata_o,
  hmr_cfg_if.regs                         cfg
);

  logic                           dmr_en_q;
  logic [hmr_pkg::NUM_CORES-1:0]  inject_q;
  logic [core_pkg::XLEN-1:0]      mismatch_cnt_q;
  logic                           access;
  logic [core_pkg::XLEN-1:0]      rdata;

  // One access per handshake
  assign access = reg_req_i && !reg_ack_o;

  assign cfg.dmr_en = dmr_en_q;
  assign cfg.inject = inject_q;

  always_comb begin
    case (reg_addr_i)
      hmr_pkg::REG_CTRL: begin
        rdata = {{(core_pkg::XLEN-hmr_pkg::NUM_CORES-1){1'b0}}, inject_q, dmr_en_q};
      end
      hmr_pkg::REG_MISMATCH: rdata = mismatch_cnt_q;
      default:               rdata = hmr_pkg::ERR_WORD;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_ack_o <= 1'b0;
    end else if (access) begin
      reg_ack_o <= 1'b1;
    end else if (!reg_req_i) begin
      reg_ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dmr_en_q       <= 1'b1;
      inject_q       <= '0;
      mismatch_cnt_q <= '0;
    end else begin
      // Inject bits are one-shot
      inject_q <= inject_q & ~cfg.inject_done;
      if (cfg.mismatch && (mismatch_cnt_q != '1)) begin
        mismatch_cnt_q <= mismatch_cnt_q + 1'b1;
      end
      if (access && reg_we_i) begin
        if (reg_addr_i == hmr_pkg::REG_CTRL) begin
          dmr_en_q <= reg_wdata_i[0];
          inject_q <= reg_wdata_i[hmr_pkg::NUM_CORES:1];
        end else if (reg_addr_i == hmr_pkg::REG_MISMATCH) begin
          mismatch_cnt_q <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      reg_rdata_o <= rdata;
    end
  end

  // Issuer keeps req high until it has seen ack
  assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(reg_req_i) |-> reg_ack_o)
    else $error("reg_req_i dropped before reg_ack_o");

endmodule

// ==== hw/hmr_pkg.sv ====
/*
 * Redundancy-side definitions for the DMR unit: register map of the
 * configuration port, lockstep controller states and the error word
 */

package hmr_pkg;

  // Number of lockstepped cores
  localparam int unsigned NUM_CORES = 2;

  // Register port address width
  localparam int unsigned REG_ADDR_W = 4;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 4'd0;
  localparam logic [REG_ADDR_W-1:0] REG_MISMATCH = 4'd1;

  // Read value for unmapped addresses
  localparam logic [31:0] ERR_WORD = 32'hBADCAB1E;

  // Lockstep controller FSM
  typedef enum logic [2:0] {
    S_IDLE,
    S_EXEC,
    S_CHECK,
    S_RESTORE,
    S_ACK
  } ctrl_state_e;

endpackage

// ==== hw/lockstep_ctrl.sv ====
/*
 * Lockstep controller. Dispatches each instruction to both cores,
 * compares results, keeps a backup register file of agreed commits
 * and on a mismatch restores both cores and re-executes
 */

`timescale 1ns/1ps

module lockstep_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            instr_req_i,
  input  core_pkg::opcode_e               instr_op_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rd_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs1_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs2_i,
  input  logic [core_pkg::IMM_W-1:0]      instr_imm_i,
  output logic                            instr_ack_o,
  output logic [core_pkg::XLEN-1:0]       result_o,
  core_bus_if.ctrl                        core0,
  core_bus_if.ctrl                        core1,
  hmr_cfg_if.ctrl                         cfg
);

  hmr_pkg::ctrl_state_e             state_q;
  logic [core_pkg::XLEN-1:0]        backup_q [core_pkg::NUM_REGS];
  logic [core_pkg::RF_ADDR_W-1:0]   rec_idx_q;
  logic                             retry_q;
  logic                             exec;
  logic                             restoring;
  logic                             disagree;
  logic                             commit;
  logic [hmr_pkg::NUM_CORES-1:0]    fault;

  assign exec      = (state_q == hmr_pkg::S_EXEC);
  assign restoring = (state_q == hmr_pkg::S_RESTORE);

  // Re-execution after a restore runs clean
  assign fault = (exec && !retry_q) ? cfg.inject : '0;

  // Core 1 is ignored in single-core mode
  assign disagree = cfg.dmr_en && (core0.result != core1.result);
  assign commit   = (state_q == hmr_pkg::S_CHECK) && !disagree;

  assign cfg.inject_done = fault;
  assign cfg.mismatch    = (state_q == hmr_pkg::S_CHECK) && disagree;

  // Same instruction and restore data to both cores
  assign core0.exec     = exec;
  assign core0.opcode   = instr_op_i;
  assign core0.rd       = instr_rd_i;
  assign core0.rs1      = instr_rs1_i;
  assign core0.rs2      = instr_rs2_i;
  assign core0.imm      = instr_imm_i;
  assign core0.fault    = fault[0];
  assign core0.rec_we   = restoring;
  assign core0.rec_addr = rec_idx_q;
  assign core0.rec_data = backup_q[rec_idx_q];

  assign core1.exec     = exec;
  assign core1.opcode   = instr_op_i;
  assign core1.rd       = instr_rd_i;
  assign core1.rs1      = instr_rs1_i;
  assign core1.rs2      = instr_rs2_i;
  assign core1.imm      = instr_imm_i;
  assign core1.fault    = fault[1];
  assign core1.rec_we   = restoring;
  assign core1.rec_addr = rec_idx_q;
  assign core1.rec_data = backup_q[rec_idx_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= hmr_pkg::S_IDLE;
      instr_ack_o <= 1'b0;
      retry_q     <= 1'b0;
      rec_idx_q   <= '0;
    end else begin
      case (state_q)
        hmr_pkg::S_IDLE: begin
          if (instr_req_i) begin
            state_q <= hmr_pkg::S_EXEC;
            retry_q <= 1'b0;
          end
        end
        hmr_pkg::S_EXEC: state_q <= hmr_pkg::S_CHECK;
        hmr_pkg::S_CHECK: begin
          if (disagree) begin
            state_q   <= hmr_pkg::S_RESTORE;
            retry_q   <= 1'b1;
            rec_idx_q <= '0;
          end else begin
            state_q <= hmr_pkg::S_ACK;
          end
        end
        hmr_pkg::S_RESTORE: begin
          // Walk every backup entry, then re-execute
          rec_idx_q <= rec_idx_q + 1'b1;
          if (rec_idx_q == core_pkg::RF_ADDR_W'(core_pkg::NUM_REGS - 1)) begin
            state_q <= hmr_pkg::S_EXEC;
          end
        end
        hmr_pkg::S_ACK: begin
          if (!instr_ack_o) begin
            instr_ack_o <= 1'b1;
          end else if (!instr_req_i) begin
            instr_ack_o <= 1'b0;
            state_q     <= hmr_pkg::S_IDLE;
          end
        end
        default: state_q <= hmr_pkg::S_IDLE;
      endcase
    end
  end

  // Backup follows agreed commits only
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        backup_q[i] <= '0;
      end
    end else if (commit) begin
      backup_q[instr_rd_i] <= core0.result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (commit) begin
      result_o <= core0.result;
    end
  end

  // Ack only rises on an edge where req was sampled high
  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(instr_ack_o) |-> $past(instr_req_i))
    else $error("instr_ack_o rose without instr_req_i");

endmodule

// ==== hw/mini_core.sv ====
/*
 * Small register-file core. Executes one instruction per exec strobe
 * and accepts register overwrites from the recovery sequencer
 */

`timescale 1ns/1ps

module mini_core (
  input  logic      clk_i,
  input  logic      rst_i,
  core_bus_if.core  bus
);

  logic [core_pkg::XLEN-1:0] rf_q [core_pkg::NUM_REGS];
  logic [core_pkg::XLEN-1:0] op_a;
  logic [core_pkg::XLEN-1:0] op_b;
  logic [core_pkg::XLEN-1:0] alu_val;
  logic [core_pkg::XLEN-1:0] wr_val;

  // Combinational operand read
  assign op_a = rf_q[bus.rs1];
  assign op_b = rf_q[bus.rs2];

  always_comb begin
    case (bus.opcode)
      core_pkg::OP_LI:  alu_val = {{(core_pkg::XLEN-core_pkg::IMM_W){1'b0}}, bus.imm};
      core_pkg::OP_ADD: alu_val = op_a + op_b;
      core_pkg::OP_SUB: alu_val = op_a - op_b;
      core_pkg::OP_XOR: alu_val = op_a ^ op_b;
      default:          alu_val = '0;
    endcase
  end

  // Injected fault flips the LSB of the written value
  assign wr_val = alu_val ^ {{(core_pkg::XLEN-1){1'b0}}, bus.fault};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      if (bus.exec) begin
        rf_q[bus.rd] <= wr_val;
      end
      if (bus.rec_we) begin
        rf_q[bus.rec_addr] <= bus.rec_data;
      end
    end
  end

  // Result register, compared by the controller
  always_ff @(posedge clk_i) begin
    if (bus.exec) begin
      bus.result <= wr_val;
    end
  end

  // Restore and execution are separate controller phases
  assert property (@(posedge clk_i) disable iff (rst_i)
    !(bus.exec && bus.rec_we))
    else $error("exec and rec_we both high");

endmodule

// ==== tb/dmr_monitor.sv ====
/*
 * DMR testbench monitor. Follows the instruction and register ports,
 * models both cores, the backup file and the config registers,
 * and checks every result and register read
 */

`timescale 1ns/1ps

module dmr_monitor (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            instr_req_i,
  input  core_pkg::opcode_e               instr_op_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rd_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs1_i,
  input  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs2_i,
  input  logic [core_pkg::IMM_W-1:0]      instr_imm_i,
  input  logic                            instr_ack_i,
  input  logic [core_pkg::XLEN-1:0]       result_i,
  input  logic                            reg_we_i,
  input  logic [hmr_pkg::REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [core_pkg::XLEN-1:0]       reg_wdata_i,
  input  logic                            reg_ack_i,
  input  logic [core_pkg::XLEN-1:0]       reg_rdata_i,
  output int                              err_cnt_o,
  output int                              check_cnt_o
);

  // Model state per core plus the backup copy
  logic [core_pkg::XLEN-1:0]      rf0 [core_pkg::NUM_REGS];
  logic [core_pkg::XLEN-1:0]      rf1 [core_pkg::NUM_REGS];
  logic [core_pkg::XLEN-1:0]      rfb [core_pkg::NUM_REGS];
  logic                           dmr_en_m;
  logic [hmr_pkg::NUM_CORES-1:0]  inject_m;
  logic [core_pkg::XLEN-1:0]      count_m;
  logic                           instr_req_q;
  logic                           instr_ack_q;
  logic                           reg_ack_q;
  logic                           pending;
  logic [core_pkg::XLEN-1:0]      held_result;

  initial begin
    err_cnt_o   = 0;
    check_cnt_o = 0;
  end

  function automatic logic [core_pkg::XLEN-1:0] ref_result(
    input core_pkg::opcode_e              op,
    input logic [core_pkg::XLEN-1:0]      a,
    input logic [core_pkg::XLEN-1:0]      b,
    input logic [core_pkg::IMM_W-1:0]     imm
  );
    case (op)
      core_pkg::OP_LI:  return {{(core_pkg::XLEN-core_pkg::IMM_W){1'b0}}, imm};
      core_pkg::OP_ADD: return a + b;
      core_pkg::OP_SUB: return a - b;
      default:          return a ^ b;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt_o++;
    if (exp !== act) begin
      err_cnt_o++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // One completed instruction, including a rollback when the cores disagree
  task automatic model_instr();
    logic [core_pkg::XLEN-1:0] v0;
    logic [core_pkg::XLEN-1:0] v1;
    v0 = ref_result(instr_op_i, rf0[instr_rs1_i], rf0[instr_rs2_i], instr_imm_i);
    v1 = ref_result(instr_op_i, rf1[instr_rs1_i], rf1[instr_rs2_i], instr_imm_i);
    v0[0] = v0[0] ^ inject_m[0];
    v1[0] = v1[0] ^ inject_m[1];
    if (dmr_en_m && (v0 !== v1)) begin
      count_m++;
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        rf0[i] = rfb[i];
        rf1[i] = rfb[i];
      end
      v0 = ref_result(instr_op_i, rfb[instr_rs1_i], rfb[instr_rs2_i], instr_imm_i);
      v1 = v0;
    end
    rf0[instr_rd_i] = v0;
    rf1[instr_rd_i] = v1;
    rfb[instr_rd_i] = v0;
    inject_m = '0;
    check_value("result_o", v0, result_i);
  endtask

  task automatic model_reg();
    logic [core_pkg::XLEN-1:0] exp;
    if (reg_we_i) begin
      if (reg_addr_i == hmr_pkg::REG_CTRL) begin
        dmr_en_m = reg_wdata_i[0];
        inject_m = reg_wdata_i[hmr_pkg::NUM_CORES:1];
      end else if (reg_addr_i == hmr_pkg::REG_MISMATCH) begin
        count_m = '0;
      end
    end else begin
      case (reg_addr_i)
        hmr_pkg::REG_CTRL:     exp = {29'b0, inject_m, dmr_en_m};
        hmr_pkg::REG_MISMATCH: exp = count_m;
        default:               exp = hmr_pkg::ERR_WORD;
      endcase
      check_value("reg_rdata_o", exp, reg_rdata_i);
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        rf0[i] = '0;
        rf1[i] = '0;
        rfb[i] = '0;
      end
      dmr_en_m    = 1'b1;
      inject_m    = '0;
      count_m     = '0;
      instr_req_q = 1'b0;
      instr_ack_q = 1'b0;
      reg_ack_q   = 1'b0;
      pending     = 1'b0;
    end else begin
      if (instr_req_i && !instr_req_q) begin
        pending = 1'b1;
      end
      if (instr_ack_i && !instr_ack_q) begin
        if (!pending) begin
          err_cnt_o++;
          $display("Error at %0t: instr_ack_o rose with no instruction outstanding", $time);
        end
        pending     = 1'b0;
        held_result = result_i;
        model_instr();
      end else if (instr_ack_i && instr_ack_q) begin
        // Result must hold while the issuer keeps req high
        check_value("result_o (held)", held_result, result_i);
      end else if (instr_ack_q && instr_req_q) begin
        err_cnt_o++;
        $display("Error at %0t: instr_ack_o dropped while req was still high", $time);
      end
      if (reg_ack_i && !reg_ack_q) begin
        model_reg();
      end
      instr_req_q = instr_req_i;
      instr_ack_q = instr_ack_i;
      reg_ack_q   = reg_ack_i;
    end
  end

endmodule

// ==== tb/dmr_tb.sv ====
/*
 * DMR testbench top. Drives instructions and register accesses on
 * falling edges through lockstep, fault and register map scenarios
 */

`timescale 1ns/1ps

module dmr_tb;

  localparam int NUM_RANDOM = 40;
  localparam int NUM_INSTR  = NUM_RANDOM + 21;
  localparam int PERIOD_NS  = 8;
  localparam int ACK_BOUND  = 100;

  logic                            clk;
  logic                            rst;
  logic                            instr_req;
  core_pkg::opcode_e               instr_op;
  logic [core_pkg::RF_ADDR_W-1:0]  instr_rd;
  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs1;
  logic [core_pkg::RF_ADDR_W-1:0]  instr_rs2;
  logic [core_pkg::IMM_W-1:0]      instr_imm;
  logic                            instr_ack;
  logic [core_pkg::XLEN-1:0]       result;
  logic                            reg_req;
  logic                            reg_we;
  logic [hmr_pkg::REG_ADDR_W-1:0]  reg_addr;
  logic [core_pkg::XLEN-1:0]       reg_wdata;
  logic                            reg_ack;
  logic [core_pkg::XLEN-1:0]       reg_rdata;
  int                              mon_err_cnt;
  int                              check_cnt;
  int                              hs_err_cnt;
  integer                          seed = 80;

  tb_clk_gen clk_gen0 (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  dmr_top dut0 (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .instr_req_i ( instr_req ),
    .instr_op_i  ( instr_op  ),
    .instr_rd_i  ( instr_rd  ),
    .instr_rs1_i ( instr_rs1 ),
    .instr_rs2_i ( instr_rs2 ),
    .instr_imm_i ( instr_imm ),
    .instr_ack_o ( instr_ack ),
    .result_o    ( result    ),
    .reg_req_i   ( reg_req   ),
    .reg_we_i    ( reg_we    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_ack_o   ( reg_ack   ),
    .reg_rdata_o ( reg_rdata )
  );

  dmr_monitor mon0 (
    .clk_i       ( clk         ),
    .rst_i       ( rst         ),
    .instr_req_i ( instr_req   ),
    .instr_op_i  ( instr_op    ),
    .instr_rd_i  ( instr_rd    ),
    .instr_rs1_i ( instr_rs1   ),
    .instr_rs2_i ( instr_rs2   ),
    .instr_imm_i ( instr_imm   ),
    .instr_ack_i ( instr_ack   ),
    .result_i    ( result      ),
    .reg_we_i    ( reg_we      ),
    .reg_addr_i  ( reg_addr    ),
    .reg_wdata_i ( reg_wdata   ),
    .reg_ack_i   ( reg_ack     ),
    .reg_rdata_i ( reg_rdata   ),
    .err_cnt_o   ( mon_err_cnt ),
    .check_cnt_o ( check_cnt   )
  );

  task automatic await_instr_ack(input logic level);
    int n;
    n = 0;
    while (instr_ack !== level && n < ACK_BOUND) begin
      @(negedge clk);
      n++;
    end
    if (instr_ack !== level) begin
      hs_err_cnt++;
      $display("Instruction handshake stuck: ack not %0b after %0d cycles", level, ACK_BOUND);
    end
  endtask

  task automatic await_reg_ack(input logic level);
    int n;
    n = 0;
    while (reg_ack !== level && n < ACK_BOUND) begin
      @(negedge clk);
      n++;
    end
    if (reg_ack !== level) begin
      hs_err_cnt++;
      $display("Register handshake stuck: ack not %0b after %0d cycles", level, ACK_BOUND);
    end
  endtask

  // Full four-phase instruction, req held for hold extra cycles after ack
  task automatic run_instr(
    input core_pkg::opcode_e              op,
    input logic [core_pkg::RF_ADDR_W-1:0] rd,
    input logic [core_pkg::RF_ADDR_W-1:0] rs1,
    input logic [core_pkg::RF_ADDR_W-1:0] rs2,
    input logic [core_pkg::IMM_W-1:0]     imm,
    input int                             hold
  );
    @(negedge clk);
    instr_op  = op;
    instr_rd  = rd;
    instr_rs1 = rs1;
    instr_rs2 = rs2;
    instr_imm = imm;
    instr_req = 1'b1;
    @(negedge clk);
    await_instr_ack(1'b1);
    repeat (hold) @(negedge clk);
    instr_req = 1'b0;
    await_instr_ack(1'b0);
  endtask

  // Registers 0 to 7 only, so operands are often live values
  task automatic random_instr();
    logic [31:0] r;
    logic [31:0] v;
    r = $random(seed);
    v = $random(seed);
    run_instr(core_pkg::opcode_e'(r[1:0]), {2'b00, r[4:2]}, {2'b00, r[7:5]},
              {2'b00, r[10:8]}, v[15:0], 0);
  endtask

  task automatic reg_access(input logic we, input logic [3:0] addr, input logic [31:0] wdata);
    @(negedge clk);
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    reg_req   = 1'b1;
    @(negedge clk);
    await_reg_ack(1'b1);
    reg_req = 1'b0;
    await_reg_ack(1'b0);
  endtask

  initial begin
    #(NUM_INSTR * 40 * PERIOD_NS + 2000);
    $display("Watchdog expired: simulation ran past its time limit");
    $display("Regression failed");
    $finish;
  end

  initial begin
    instr_req  = 1'b0;
    instr_op   = core_pkg::OP_LI;
    instr_rd   = '0;
    instr_rs1  = '0;
    instr_rs2  = '0;
    instr_imm  = '0;
    reg_req    = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    hs_err_cnt = 0;
    wait (rst === 1'b0);
    @(negedge clk);

    // Reset state, then random lockstep execution
    run_instr(core_pkg::OP_ADD, 5'd5, 5'd3, 5'd7, 16'h0, 0);
    reg_access(1'b0, hmr_pkg::REG_CTRL, 32'h0);
    reg_access(1'b0, hmr_pkg::REG_MISMATCH, 32'h0);
    repeat (NUM_RANDOM) random_instr();

    // Faults with DMR enabled, core 1 then core 0
    reg_access(1'b1, hmr_pkg::REG_CTRL, 32'h5);
    random_instr();
    reg_access(1'b0, hmr_pkg::REG_MISMATCH, 32'h0);
    reg_access(1'b1, hmr_pkg::REG_CTRL, 32'h3);
    random_instr();
    reg_access(1'b0, hmr_pkg::REG_MISMATCH, 32'h0);
    reg_access(1'b0, hmr_pkg::REG_CTRL, 32'h0);
    repeat (8) random_instr();

    // Single-core mode faults, caught once DMR is back on
    reg_access(1'b1, hmr_pkg::REG_CTRL, 32'h2);
    run_instr(core_pkg::OP_LI, 5'd10, 5'd0, 5'd0, 16'h1234, 0);
    reg_access(1'b1, hmr_pkg::REG_CTRL, 32'h4);
    run_instr(core_pkg::OP_LI, 5'd11, 5'd0, 5'd0, 16'h00F0, 0);
    reg_access(1'b0, hmr_pkg::REG_MISMATCH, 32'h0);
    reg_access(1'b1, hmr_pkg::REG_CTRL, 32'h1);
    run_instr(core_pkg::OP_SUB, 5'd12, 5'd10, 5'd11, 16'h0, 0);
    reg_access(1'b0, hmr_pkg::REG_MISMATCH, 32'h0);
    run_instr(core_pkg::OP_ADD, 5'd13, 5'd12, 5'd10, 16'h0, 0);

    // Register map
    reg_access(1'b1, hmr_pkg::REG_CTRL, 32'h7);
    reg_access(1'b0, hmr_pkg::REG_CTRL, 32'h0);
    run_instr(core_pkg::OP_SUB, 5'd14, 5'd13, 5'd12, 16'h0, 0);
    reg_access(1'b0, hmr_pkg::REG_CTRL, 32'h0);
    reg_access(1'b1, hmr_pkg::REG_MISMATCH, 32'h0);
    reg_access(1'b0, hmr_pkg::REG_MISMATCH, 32'h0);
    for (int a = 2; a < 16; a++) begin
      reg_access(1'b0, a[3:0], 32'h0);
    end
    reg_access(1'b1, 4'd5, 32'hFFFF_FFFF);
    reg_access(1'b0, hmr_pkg::REG_CTRL, 32'h0);

    // Issuer holds req after ack
    run_instr(core_pkg::OP_ADD, 5'd1, 5'd2, 5'd3, 16'h0, 6);
    repeat (4) random_instr();

    repeat (2) @(negedge clk);
    $display("Checks %0d, monitor errors %0d, handshake errors %0d",
             check_cnt, mon_err_cnt, hs_err_cnt);
    if (mon_err_cnt == 0 && hs_err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
/*
 * Testbench clock and reset source. 8 ns clock, reset held
 * high for the first 4 rising edges
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam real HALF_PERIOD = 4.0;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge, in step with the stimulus
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule
